// File: hdl/hwlp_pkg.sv
/*
  Hardware loop register definitions.
  Holds the iteration count type and the selector that picks which loop
  register a configuration write lands in. The loop register bank, the
  controller and the top level refer to these by scoped name.
*/

package hwlp_pkg;

  ////////////////////////////////////////
  // iteration count
  ////////////////////////////////////////

  // width of one loop's iteration counter
  localparam int unsigned CNT_W = 16;

  // unsigned, zero means the loop is exhausted
  typedef logic [CNT_W-1:0] cnt_t;

  ////////////////////////////////////////
  // configuration field selector
  ////////////////////////////////////////

  // which register of the addressed loop a config write updates
  // encoding 2'b11 is unused and the write is dropped
  typedef enum logic [1:0] {
    CFG_START = 2'b00,
    CFG_END   = 2'b01,
    CFG_COUNT = 2'b10
  } cfg_field_e;

endpackage

// File: hdl/fetch_pkg.sv
/*
  Fetch sequencer definitions.
  Instruction address type, the sequential PC increment and the run state
  encoding of the loop controller. Used through scoped names only.
*/

package fetch_pkg;

  // instruction address, byte granular
  typedef logic [31:0] addr_t;

  // one 32-bit instruction per fetch
  localparam addr_t PC_STEP = 32'd4;

  ////////////////////////////////////////
  // run state of the sequencer
  ////////////////////////////////////////

  // idle accepts configuration and go
  // run streams addresses until the stop address is accepted
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } run_state_e;

endpackage

// File: hdl/hwlp_regs.sv
/*
  Hardware loop register bank.
  Keeps start address, end address and iteration count for each of the
  N_REGS loops. Configuration writes arrive already qualified by the
  handshake; the controller decrements counts through dec_cnt_i.
*/

`timescale 1ns/10ps

module hwlp_regs #(
  parameter int unsigned N_REGS = 2,
  parameter int unsigned IDX_W  = (N_REGS > 1) ? $clog2(N_REGS) : 1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // configuration write, one field of one loop per cycle
  input  logic                                  cfg_we_i,
  input  logic [IDX_W-1:0]                      cfg_idx_i,
  input  hwlp_pkg::cfg_field_e                  cfg_field_i,
  input  fetch_pkg::addr_t                      cfg_data_i,

  // decrement strobes from the controller
  input  logic [N_REGS-1:0]                     dec_cnt_i,

  // register contents towards the controller
  output fetch_pkg::addr_t [N_REGS-1:0]         start_addr_o,
  output fetch_pkg::addr_t [N_REGS-1:0]         end_addr_o,
  output hwlp_pkg::cnt_t   [N_REGS-1:0]         count_o
);

  fetch_pkg::addr_t [N_REGS-1:0] start_q;
  fetch_pkg::addr_t [N_REGS-1:0] end_q;
  hwlp_pkg::cnt_t   [N_REGS-1:0] cnt_q;

  ////////////////////////////////////////
  // register banks
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= '0;
      end_q   <= '0;
      cnt_q   <= '0;
    end else begin
      for (int i = 0; i < N_REGS; i++) begin
        // indices beyond N_REGS-1 never match, so such writes are lost
        if (cfg_we_i && (cfg_idx_i == IDX_W'(i))) begin
          case (cfg_field_i)
            hwlp_pkg::CFG_START: start_q[i] <= cfg_data_i;
            hwlp_pkg::CFG_END:   end_q[i]   <= cfg_data_i;
            // count keeps only the low bits of the data word
            hwlp_pkg::CFG_COUNT: cnt_q[i]   <= cfg_data_i[hwlp_pkg::CNT_W-1:0];
            default: ;
          endcase
        end else if (dec_cnt_i[i] && (cnt_q[i] != '0)) begin
          // saturate at zero
          cnt_q[i] <= cnt_q[i] - hwlp_pkg::cnt_t'(1);
        end
      end
    end
  end

  assign start_addr_o = start_q;
  assign end_addr_o   = end_q;
  assign count_o      = cnt_q;

endmodule

// File: hdl/hwlp_ctrl.sv
/*
  Hardware loop controller.
  Runs the idle/run state machine, compares the presented PC against every
  loop end address and picks the lowest-numbered live loop. It chooses the
  next fetch address, strobes the count decrement on accept and signals the
  end of the run once the stop address has been taken.
*/

`timescale 1ns/10ps

module hwlp_ctrl #(
  parameter int unsigned N_REGS = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // run control
  input  logic                                  go_i,
  input  fetch_pkg::addr_t                      boot_addr_i,
  input  fetch_pkg::addr_t                      stop_addr_i,

  // fetch port as seen at the output stage
  input  fetch_pkg::addr_t                      pc_i,
  input  logic                                  pc_valid_i,
  input  logic                                  pc_ready_i,

  // loop registers
  input  fetch_pkg::addr_t [N_REGS-1:0]         start_addr_i,
  input  fetch_pkg::addr_t [N_REGS-1:0]         end_addr_i,
  input  hwlp_pkg::cnt_t   [N_REGS-1:0]         count_i,

  output logic                                  cfg_ready_o,
  output logic [N_REGS-1:0]                     dec_cnt_o,

  // towards the PC generator
  output logic                                  load_boot_o,
  output logic                                  advance_o,
  output fetch_pkg::addr_t                      next_pc_o,
  output logic                                  stop_o,

  output logic                                  done_o
);

  fetch_pkg::run_state_e state_q;
  fetch_pkg::addr_t      stop_q;
  logic                  done_q;

  logic                  start_run;
  logic                  accept;
  logic                  at_stop;

  logic [N_REGS-1:0]     pc_is_end;
  logic [N_REGS-1:0]     dec_sel;
  logic                  hit;
  logic                  last_iter;
  fetch_pkg::addr_t      targ_addr;

  ////////////////////////////////////////
  // run state machine
  ////////////////////////////////////////

  // go only counts while idle
  assign start_run = go_i && (state_q == fetch_pkg::ST_IDLE);

  // handshake on the fetch port, formed here only
  assign accept  = pc_valid_i && pc_ready_i;
  assign at_stop = (pc_i == stop_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= stop_o;
      case (state_q)
        fetch_pkg::ST_IDLE: begin
          if (start_run) begin
            state_q <= fetch_pkg::ST_RUN;
          end
        end
        default: begin
          // back to idle in the cycle pc_valid drops
          if (stop_o) begin
            state_q <= fetch_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  // stop address held for the whole run
  always_ff @(posedge clk) begin
    if (start_run) begin
      stop_q <= stop_addr_i;
    end
  end

  assign cfg_ready_o = (state_q == fetch_pkg::ST_IDLE);
  assign load_boot_o = start_run;
  assign done_o      = done_q;

  ////////////////////////////////////////
  // end address comparison
  ////////////////////////////////////////

  // a loop is live at pc only while its count is non-zero
  always_comb begin
    for (int i = 0; i < N_REGS; i++) begin
      pc_is_end[i] = (pc_i == end_addr_i[i]) && (count_i[i] != '0);
    end
  end

  // priority pick, lowest index wins
  always_comb begin
    hit       = 1'b0;
    dec_sel   = '0;
    last_iter = 1'b0;
    targ_addr = '0;
    for (int i = 0; i < N_REGS; i++) begin
      if (pc_is_end[i] && !hit) begin
        hit        = 1'b1;
        dec_sel[i] = 1'b1;
        targ_addr  = start_addr_i[i];
        // count of one means this pass is the final one
        last_iter  = (count_i[i] == hwlp_pkg::cnt_t'(1));
      end
    end
  end

  ////////////////////////////////////////
  // next address decision
  ////////////////////////////////////////

  // the decrement applies even on the stop accept
  assign dec_cnt_o = accept ? dec_sel : '0;

  assign advance_o = accept && !at_stop;
  assign stop_o    = accept && at_stop;

  always_comb begin
    if (state_q == fetch_pkg::ST_IDLE) begin
      // nothing to step from, offer the boot address
      next_pc_o = boot_addr_i;
    end else if (hit && !last_iter) begin
      next_pc_o = targ_addr;
    end else begin
      // no loop or final pass, fall through
      next_pc_o = pc_i + fetch_pkg::PC_STEP;
    end
  end

endmodule

// File: hdl/pc_gen.sv
/*
  PC output stage of the fetch stream.
  Holds the presented address and its valid flag. The controller decides
  what comes next; this stage only loads, advances, holds under
  back-pressure and drops valid after the stop address is taken.
*/

`timescale 1ns/10ps

module pc_gen (
  input  logic             clk,
  input  logic             rst_n,

  // controls from the loop controller
  input  logic             load_boot_i,
  input  fetch_pkg::addr_t boot_addr_i,
  input  logic             advance_i,
  input  fetch_pkg::addr_t next_pc_i,
  input  logic             stop_i,

  // fetch stream
  output fetch_pkg::addr_t pc_o,
  output logic             pc_valid_o
);

  fetch_pkg::addr_t pc_q;
  logic             valid_q;

  ////////////////////////////////////////
  // valid flag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load_boot_i) begin
      valid_q <= 1'b1;
    end else if (stop_i) begin
      valid_q <= 1'b0;
    end
  end

  // address register, holds when neither load nor advance
  always_ff @(posedge clk) begin
    if (load_boot_i) begin
      pc_q <= boot_addr_i;
    end else if (advance_i) begin
      pc_q <= next_pc_i;
    end
  end

  assign pc_o       = pc_q;
  assign pc_valid_o = valid_q;

endmodule

// File: hdl/hwlp_fetch_top.sv
/*
  Hardware loop fetch sequencer, top level.
  Connects the loop register bank, the loop controller and the PC output
  stage. Program loops through the config port while idle, pulse go_i and
  take addresses from the fetch port until done_o pulses.
*/

`timescale 1ns/10ps

module hwlp_fetch_top #(
  parameter int unsigned N_REGS = 2,
  parameter int unsigned IDX_W  = (N_REGS > 1) ? $clog2(N_REGS) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // configuration write port
  input  logic                 cfg_valid_i,
  output logic                 cfg_ready_o,
  input  logic [IDX_W-1:0]     cfg_idx_i,
  input  hwlp_pkg::cfg_field_e cfg_field_i,
  input  fetch_pkg::addr_t     cfg_data_i,

  // run start, both addresses sampled with go
  input  logic                 go_i,
  input  fetch_pkg::addr_t     boot_addr_i,
  input  fetch_pkg::addr_t     stop_addr_i,

  // fetch stream
  output logic                 pc_valid_o,
  input  logic                 pc_ready_i,
  output fetch_pkg::addr_t     pc_o,

  output logic                 done_o
);

  fetch_pkg::addr_t [N_REGS-1:0] start_addr;
  fetch_pkg::addr_t [N_REGS-1:0] end_addr;
  hwlp_pkg::cnt_t   [N_REGS-1:0] count;
  logic [N_REGS-1:0]             dec_cnt;

  logic                          cfg_we;
  logic                          load_boot;
  logic                          advance;
  logic                          stop;
  fetch_pkg::addr_t              next_pc;

  // config handshake, ready only while idle
  assign cfg_we = cfg_valid_i && cfg_ready_o;

  hwlp_regs #(
    .N_REGS (N_REGS),
    .IDX_W  (IDX_W)
  ) regs0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_we_i     (cfg_we),
    .cfg_idx_i    (cfg_idx_i),
    .cfg_field_i  (cfg_field_i),
    .cfg_data_i   (cfg_data_i),
    .dec_cnt_i    (dec_cnt),
    .start_addr_o (start_addr),
    .end_addr_o   (end_addr),
    .count_o      (count)
  );

  hwlp_ctrl #(
    .N_REGS (N_REGS)
  ) ctrl0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .go_i         (go_i),
    .boot_addr_i  (boot_addr_i),
    .stop_addr_i  (stop_addr_i),
    .pc_i         (pc_o),
    .pc_valid_i   (pc_valid_o),
    .pc_ready_i   (pc_ready_i),
    .start_addr_i (start_addr),
    .end_addr_i   (end_addr),
    .count_i      (count),
    .cfg_ready_o  (cfg_ready_o),
    .dec_cnt_o    (dec_cnt),
    .load_boot_o  (load_boot),
    .advance_o    (advance),
    .next_pc_o    (next_pc),
    .stop_o       (stop),
    .done_o       (done_o)
  );

  pc_gen pcgen0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_boot_i (load_boot),
    .boot_addr_i (boot_addr_i),
    .advance_i   (advance),
    .next_pc_i   (next_pc),
    .stop_i      (stop),
    .pc_o        (pc_o),
    .pc_valid_o  (pc_valid_o)
  );

endmodule

// File: dv/hwlp_tb.sv
/*
  Testbench for the hardware loop fetch sequencer.
  Programs loops through the config port, starts runs with go_i and checks
  every accepted fetch address against a reference model of the loop rule.
  pc_ready_i gets random stalls in some tests, and a watchdog bounds the run.
*/

`timescale 1ns/10ps

module hwlp_tb;

  localparam int N_REGS       = 2;
  localparam int IDX_W        = (N_REGS > 1) ? $clog2(N_REGS) : 1;
  localparam int RST_CYCLES   = 16;
  // ready is never low more than three cycles in a row
  localparam int STALL_FACTOR = 4;
  localparam int MAX_LEN      = 256;

  logic                 clk;
  logic                 rst_n;
  logic                 cfg_valid_i;
  logic                 cfg_ready_o;
  logic [IDX_W-1:0]     cfg_idx_i;
  hwlp_pkg::cfg_field_e cfg_field_i;
  fetch_pkg::addr_t     cfg_data_i;
  logic                 go_i;
  fetch_pkg::addr_t     boot_addr_i;
  fetch_pkg::addr_t     stop_addr_i;
  logic                 pc_valid_o;
  logic                 pc_ready_i;
  fetch_pkg::addr_t     pc_o;
  logic                 done_o;

  // model copy of the loop registers
  fetch_pkg::addr_t     m_start [N_REGS];
  fetch_pkg::addr_t     m_end [N_REGS];
  hwlp_pkg::cnt_t       m_cnt [N_REGS];

  fetch_pkg::addr_t     exp_q [$];
  int                   exp_idx;
  int                   done_cnt;
  int                   errors;
  int                   n_tests;
  int                   stall_pct;
  int                   wd_budget;
  bit                   cfg_saw_done;
  bit                   hold_pend;
  fetch_pkg::addr_t     hold_pc;

  hwlp_fetch_top #(
    .N_REGS (N_REGS)
  ) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_valid_i (cfg_valid_i),
    .cfg_ready_o (cfg_ready_o),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_field_i (cfg_field_i),
    .cfg_data_i  (cfg_data_i),
    .go_i        (go_i),
    .boot_addr_i (boot_addr_i),
    .stop_addr_i (stop_addr_i),
    .pc_valid_o  (pc_valid_o),
    .pc_ready_i  (pc_ready_i),
    .pc_o        (pc_o),
    .done_o      (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model of the loop rule
  ////////////////////////////////////////

  // fills exp_q with the stall-free address list and updates the model counts
  function automatic void build_expected(input fetch_pkg::addr_t boot,
                                         input fetch_pkg::addr_t stop);
    fetch_pkg::addr_t p;
    fetch_pkg::addr_t nxt;
    int sel;
    bit reached;
    p = boot;
    reached = 1'b0;
    exp_q.delete();
    while (!reached && (exp_q.size() < MAX_LEN)) begin
      exp_q.push_back(p);
      // scan downwards so the lowest live index is left in sel
      sel = -1;
      for (int i = N_REGS - 1; i >= 0; i--) begin
        if ((m_end[i] == p) && (m_cnt[i] != 16'd0)) begin
          sel = i;
        end
      end
      nxt = p + 32'd4;
      if (sel >= 0) begin
        if (m_cnt[sel] >= 16'd2) begin
          nxt = m_start[sel];
        end
        m_cnt[sel] = m_cnt[sel] - 16'd1;
      end
      // the stop accept still takes its decrement above
      reached = (p == stop);
      p = nxt;
    end
    if (!reached) begin
      errors++;
      $display("reference stream never reached the stop address %h", stop);
    end
  endfunction

  ////////////////////////////////////////
  // ready driver and monitor
  ////////////////////////////////////////

  initial begin
    int stall_run;
    stall_run = 0;
    pc_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      if ((stall_pct == 0) || (stall_run >= 3)) begin
        pc_ready_i = 1'b1;
        stall_run = 0;
      end else if (($urandom % 100) < stall_pct) begin
        pc_ready_i = 1'b0;
        stall_run++;
      end else begin
        pc_ready_i = 1'b1;
        stall_run = 0;
      end
    end
  end

  // compares each accepted address in order and checks holds under stalls
  always @(posedge clk) begin
    if (rst_n) begin
      if (hold_pend && (!pc_valid_o || (pc_o !== hold_pc))) begin
        errors++;
        $display("Fail pc_o held exp %h got %h valid %h", hold_pc, pc_o, pc_valid_o);
      end
      hold_pend = pc_valid_o && !pc_ready_i;
      hold_pc = pc_o;
      if (pc_valid_o && pc_ready_i) begin
        if (exp_idx >= exp_q.size()) begin
          errors++;
          $display("address %h accepted after the expected stream ended", pc_o);
        end else if (pc_o !== exp_q[exp_idx]) begin
          errors++;
          $display("Fail pc_o #%0d exp %h got %h", exp_idx, exp_q[exp_idx], pc_o);
        end
        exp_idx++;
      end
      if (done_o) begin
        done_cnt++;
      end
    end
  end

  // the watchdog budget grows with every run and config write
  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= wd_budget) begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog expired after %0d cycles, a run did not finish", cycles);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////
  // stimulus tasks entered and left on a falling edge
  ////////////////////////////////////////

  task automatic config_write(input int idx, input hwlp_pkg::cfg_field_e fld,
                              input fetch_pkg::addr_t data);
    bit taken;
    cfg_valid_i = 1'b1;
    cfg_idx_i = IDX_W'(idx);
    cfg_field_i = fld;
    cfg_data_i = data;
    cfg_saw_done = 1'b0;
    taken = 1'b0;
    wd_budget += 4;
    while (!taken) begin
      @(posedge clk);
      if (done_o) begin
        cfg_saw_done = 1'b1;
      end
      taken = cfg_ready_o;
    end
    case (fld)
      hwlp_pkg::CFG_START: m_start[idx] = data;
      hwlp_pkg::CFG_END:   m_end[idx] = data;
      default:             m_cnt[idx] = data[15:0];
    endcase
    @(negedge clk);
    cfg_valid_i = 1'b0;
  endtask

  task automatic start_run(input fetch_pkg::addr_t boot, input fetch_pkg::addr_t stop);
    build_expected(boot, stop);
    exp_idx = 0;
    done_cnt = 0;
    wd_budget += exp_q.size() * STALL_FACTOR + 20;
    boot_addr_i = boot;
    stop_addr_i = stop;
    go_i = 1'b1;
    @(negedge clk);
    go_i = 1'b0;
    // boot address is presented one cycle after go
    if (!pc_valid_o || (pc_o !== boot)) begin
      errors++;
      $display("Fail pc_o after go exp %h got %h valid %h", boot, pc_o, pc_valid_o);
    end
  endtask

  task automatic finish_run(input string name, input int err0);
    while (done_cnt == 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    if (exp_idx != exp_q.size()) begin
      errors++;
      $display("run ended after %0d of %0d addresses", exp_idx, exp_q.size());
    end
    if (done_cnt != 1) begin
      errors++;
      $display("done_o pulsed %0d times in one run", done_cnt);
    end
    if (pc_valid_o || !cfg_ready_o) begin
      errors++;
      $display("sequencer not idle after done_o");
    end
    n_tests++;
    $display("test %-32s %3d addresses  %s", name, exp_q.size(),
             (errors == err0) ? "ok" : "FAILED");
  endtask

  task automatic run_test(input string name, input fetch_pkg::addr_t boot,
                          input fetch_pkg::addr_t stop);
    int err0;
    err0 = errors;
    start_run(boot, stop);
    finish_run(name, err0);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int err0;
    void'($urandom(32'h3707));
    errors = 0;
    n_tests = 0;
    stall_pct = 0;
    exp_idx = 0;
    done_cnt = 0;
    hold_pend = 1'b0;
    hold_pc = '0;
    wd_budget = RST_CYCLES + 40;
    rst_n = 1'b0;
    cfg_valid_i = 1'b0;
    cfg_idx_i = '0;
    cfg_field_i = hwlp_pkg::CFG_START;
    cfg_data_i = '0;
    go_i = 1'b0;
    boot_addr_i = '0;
    stop_addr_i = '0;
    for (int i = 0; i < N_REGS; i++) begin
      m_start[i] = '0;
      m_end[i] = '0;
      m_cnt[i] = '0;
    end
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    if (pc_valid_o || done_o || !cfg_ready_o) begin
      errors++;
      $display("outputs not at their reset values");
    end

    run_test("no loops, sequential", 32'h100, 32'h120);

    config_write(0, hwlp_pkg::CFG_START, 32'h200);
    config_write(0, hwlp_pkg::CFG_END, 32'h20C);
    config_write(0, hwlp_pkg::CFG_COUNT, 32'd4);
    run_test("single loop, count 4", 32'h1F8, 32'h214);
    run_test("single loop, rerun exhausted", 32'h1F8, 32'h214);

    // both loops end on the same instruction
    config_write(0, hwlp_pkg::CFG_START, 32'h300);
    config_write(0, hwlp_pkg::CFG_END, 32'h30C);
    config_write(0, hwlp_pkg::CFG_COUNT, 32'd2);
    config_write(1, hwlp_pkg::CFG_START, 32'h308);
    config_write(1, hwlp_pkg::CFG_END, 32'h30C);
    config_write(1, hwlp_pkg::CFG_COUNT, 32'd3);
    run_test("shared end, loop 0 first", 32'h300, 32'h314);
    run_test("shared end, loop 1 takes over", 32'h300, 32'h314);

    config_write(0, hwlp_pkg::CFG_COUNT, ($urandom % 5) + 1);
    config_write(1, hwlp_pkg::CFG_COUNT, ($urandom % 5) + 1);
    stall_pct = 50;
    run_test("random back-pressure", 32'h2F8, 32'h314);
    stall_pct = 0;

    // write offered right after go has to wait for the end of the run
    err0 = errors;
    start_run(32'h400, 32'h41C);
    config_write(0, hwlp_pkg::CFG_COUNT, ($urandom % 5) + 1);
    if (!cfg_saw_done) begin
      errors++;
      $display("config write accepted while the run was still going");
    end
    finish_run("config offered while running", err0);
    config_write(0, hwlp_pkg::CFG_START, 32'h500);
    config_write(0, hwlp_pkg::CFG_END, 32'h508);
    config_write(1, hwlp_pkg::CFG_START, 32'h504);
    config_write(1, hwlp_pkg::CFG_END, 32'h50C);
    config_write(1, hwlp_pkg::CFG_COUNT, ($urandom % 5) + 1);
    stall_pct = 30;
    run_test("reconfigured, random counts", 32'h500, 32'h514);
    stall_pct = 0;

    // stop on the loop's last instruction so the rerun shows the decrement
    config_write(0, hwlp_pkg::CFG_START, 32'h600);
    config_write(0, hwlp_pkg::CFG_END, 32'h610);
    config_write(0, hwlp_pkg::CFG_COUNT, 32'd3);
    config_write(1, hwlp_pkg::CFG_COUNT, 32'd0);
    run_test("stop inside loop body", 32'h600, 32'h610);
    run_test("resume after stop decrement", 32'h600, 32'h614);

    $display("%0d tests run, %0d errors", n_tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: all.f
hdl/hwlp_pkg.sv
hdl/fetch_pkg.sv
hdl/hwlp_regs.sv
hdl/hwlp_ctrl.sv
hdl/pc_gen.sv
hdl/hwlp_fetch_top.sv
dv/hwlp_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module hwlp_tb -f all.f -o hwlp_sim \
  && ./obj_dir/hwlp_sim | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
